// File: list.f
+incdir+source
source/fm_map_pkg.sv
source/fm_ctrl_pkg.sv
source/fm_prescaler.sv
source/fm_global_regs.sv
source/fm_update_decode.sv
source/fm_busy.sv
source/fm_mmr.sv
verification/fm_mmr_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fm_mmr testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fm_mmr_tb \
    -o fm_mmr_sim && ./obj_dir/fm_mmr_sim | tee sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/fm_mmr_tb.sv
/*
 * FM host register interface testbench
 * Directed tests for timers, DAC, update commands, channel 3, busy and prescaler
 */
`default_nettype none

`include "fm_settings.svh"

module fm_mmr_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Reset, setup writes, six busy periods of up to 200 cycles, spacing checks
    localparam int timeout_cycles = 16 + 400 + 6 * 200 + 200 + 400;

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic [`FM_DIN_W-1:0]    din;
    logic                    write;
    logic [1:0]              addr;
    logic                    busy;
    logic                    clk_en;
    fm_ctrl_pkg::fm_timer_t  timer;
    fm_ctrl_pkg::fm_lfo_t    lfo;
    fm_ctrl_pkg::fm_test_t   test;
    fm_ctrl_pkg::fm_pcm_t    pcm;
    fm_ctrl_pkg::fm_ch3_t    ch3;
    fm_ctrl_pkg::fm_update_t update;

    logic [23:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    fm_mmr dut0 (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .write  (write),
        .addr   (addr),
        .busy   (busy),
        .clk_en (clk_en),
        .timer  (timer),
        .lfo    (lfo),
        .test   (test),
        .pcm    (pcm),
        .ch3    (ch3),
        .update (update)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // Polynomial x^24 + x^23 + x^22 + x^17 + 1 stepped once per bit
    function automatic logic [7:0] next_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = {lfsr[22:0], lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16]};
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Address write only that returns on the falling edge after it is taken
    task automatic drive_select(input logic prt, input logic [7:0] regn);
        @(posedge clk);
        addr  <= {prt, 1'b0};
        din   <= regn;
        write <= 1'b1;
        @(posedge clk);
        write <= 1'b0;
        @(negedge clk);
    endtask

    task automatic drive_data(input logic prt, input logic [7:0] data);
        @(posedge clk);
        addr  <= {prt, 1'b1};
        din   <= data;
        write <= 1'b1;
        @(posedge clk);
        write <= 1'b0;
        @(negedge clk);
    endtask

    task automatic write_reg(input logic prt, input logic [7:0] regn, input logic [7:0] data);
        drive_select(prt, regn);
        drive_data(prt, data);
    endtask

    // Called on a falling edge; returns once an enable has been applied
    task automatic wait_clk_en;
        while (!clk_en) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic measure_spacing(output int gap);
        int n;
        while (!clk_en) @(negedge clk);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!clk_en);
        gap = n;
    endtask

    task automatic reset_values;
        check("busy after reset", busy, 1'b0);
        check("DAC strobe after reset", pcm.wr, 1'b0);
        check("DAC enable after reset", pcm.en, 1'b0);
        check("timer clears after reset", {timer.clr_a, timer.clr_b}, 2'b00);
        check("LFO enable after reset", lfo.en, 1'b0);
        check("mode bits after reset", {ch3.effect, ch3.csm}, 2'b00);
        check("update kind after reset", update.kind, fm_map_pkg::upd_none);
    endtask

    task automatic timer_regs;
        logic [7:0] hi, lo, vb, ctl;
        hi = next_byte();
        lo = next_byte();
        vb = next_byte();
        write_reg(1'b0, 8'h24, hi);
        write_reg(1'b0, 8'h25, lo);
        write_reg(1'b0, 8'h26, vb);
        check("timer A value", timer.value_a, {hi, lo[1:0]});
        check("timer B value", timer.value_b, vb);
        ctl = next_byte() | 8'h30; // Both clears set
        write_reg(1'b0, 8'h27, ctl);
        check("load bits", {timer.load_b, timer.load_a}, ctl[1:0]);
        check("irq enables", {timer.irq_en_b, timer.irq_en_a}, ctl[3:2]);
        check("clear bits", {timer.clr_b, timer.clr_a}, 2'b11);
        check("effect mode", ch3.effect, ctl[7] | ctl[6]);
        check("CSM mode", ch3.csm, ctl[7:6] == 2'b10);
        wait_clk_en();
        check("clear bits after enable", {timer.clr_b, timer.clr_a}, 2'b00);
        check("load bits held", {timer.load_b, timer.load_a}, ctl[1:0]);
    endtask

    task automatic dac_regs;
        logic [7:0] s, e, t;
        s = next_byte();
        write_reg(1'b0, 8'h2A, s);
        check("DAC sample", pcm.sample, {~s[7], s[6:0], 1'b1});
        check("DAC strobe", pcm.wr, 1'b1);
        wait_clk_en();
        check("DAC strobe after enable", pcm.wr, 1'b0);
        e = next_byte();
        write_reg(1'b0, 8'h2B, e);
        check("DAC enable", pcm.en, e[7]);
        t = next_byte();
        write_reg(1'b0, 8'h2C, t);
        check("DAC test bit", pcm.sample, {~s[7], s[6:0], t[3]});
    endtask

    task automatic update_commands;
        logic [7:0] k, n, d, v;
        k = next_byte();
        write_reg(1'b0, 8'h28, k);
        check("key-on kind", update.kind, fm_map_pkg::upd_keyon);
        check("key-on data", update.data, k);
        n = next_byte();
        if (n[1:0] == 2'b11) n[0] = 1'b0; // Slot 3 would decode to none
        d = next_byte();
        write_reg(1'b1, {4'h4, n[3:0]}, d);
        check("TL kind", update.kind, fm_map_pkg::upd_tl);
        check("TL channel", update.ch, {1'b1, n[1:0]});
        check("TL operator", update.op, n[3:2]);
        check("TL data", update.data, d);
        write_reg(1'b0, 8'h43, next_byte());
        check("unused slot kind", update.kind, fm_map_pkg::upd_none);
        v = next_byte();
        write_reg(1'b0, 8'h22, v);
        check("LFO", lfo, v[3:0]);
        write_reg(1'b1, 8'h22, ~v);
        check("LFO after part 1 write", lfo, v[3:0]);
    endtask

    task automatic ch3_freq;
        logic [7:0] h, l, l2, h2, l3;
        h  = next_byte();
        l  = next_byte();
        l2 = next_byte();
        h2 = next_byte();
        l3 = next_byte();
        write_reg(1'b1, 8'hA4, h);
        write_reg(1'b0, 8'hA9, l);
        check("ch3 op1 block", ch3.block_op1, h[5:3]);
        check("ch3 op1 fnum", ch3.fnum_op1, {h[2:0], l});
        write_reg(1'b0, 8'hAA, l2);
        check("ch3 op2 block", ch3.block_op2, h[5:3]);
        check("ch3 op2 fnum", ch3.fnum_op2, {h[2:0], l2});
        write_reg(1'b0, 8'hAD, h2);
        write_reg(1'b0, 8'hA8, l3);
        check("ch3 op3 block", ch3.block_op3, h2[5:3]);
        check("ch3 op3 fnum", ch3.fnum_op3, {h2[2:0], l3});
    endtask

    task automatic busy_and_prescaler;
        logic [7:0] d;
        int         gap;
        int         pulses;
        measure_spacing(gap);
        check("enable spacing after reset", gap, 6);
        d = next_byte();
        write_reg(1'b0, 8'h21, d);
        check("test bits", {test.eg_stop, test.pg_stop, timer.fast}, {d[5], d[3], d[2]});
        check("busy after write", busy, 1'b1);
        pulses = 0;
        while (busy) begin
            if (clk_en) pulses++;
            @(negedge clk);
        end
        check("busy length in enables", pulses, 1 << `FM_BUSY_CNT_W);
        drive_select(1'b0, 8'h2F);
        measure_spacing(gap);
        check("enable spacing after 2F", gap, 2);
        drive_select(1'b0, 8'h2D);
        measure_spacing(gap);
        check("enable spacing after 2D", gap, 6);
        drive_select(1'b0, 8'h2E);
        measure_spacing(gap);
        check("enable spacing after 2E", gap, 3);
    endtask

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        cen   = 1'b1;
        din   = '0;
        write = 1'b0;
        addr  = 2'b00;
        lfsr  = 24'd83179;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_values();
        busy_and_prescaler();
        timer_regs();
        dac_regs();
        update_commands();
        ch3_freq();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/fm_mmr.sv
/*
 * FM host register interface top level
 * Prescaler, global registers, update decoder and busy flag
 */
`default_nettype none

`include "fm_settings.svh"

module fm_mmr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [`FM_DIN_W-1:0]    din,
    input  logic                    write,
    input  logic [1:0]              addr,
    output logic                    busy,
    output logic                    clk_en,
    output fm_ctrl_pkg::fm_timer_t  timer,
    output fm_ctrl_pkg::fm_lfo_t    lfo,
    output fm_ctrl_pkg::fm_test_t   test,
    output fm_ctrl_pkg::fm_pcm_t    pcm,
    output fm_ctrl_pkg::fm_ch3_t    ch3,
    output fm_ctrl_pkg::fm_update_t update
);

    logic [1:0]          div_setting;
    fm_map_pkg::fm_reg_e sel_reg;
    logic                part;
    logic                data_wr;

    fm_prescaler u_prescaler (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .div_setting (div_setting),
        .clk_en      (clk_en)
    );

    fm_global_regs u_global_regs (
        .clk         (clk),
        .rst         (rst),
        .clk_en      (clk_en),
        .din         (din),
        .write       (write),
        .addr        (addr),
        .div_setting (div_setting),
        .sel_reg     (sel_reg),
        .part        (part),
        .data_wr     (data_wr),
        .timer       (timer),
        .lfo         (lfo),
        .test        (test),
        .pcm         (pcm),
        .ch3         (ch3)
    );

    // Command for the external operator register file
    fm_update_decode u_update_decode (
        .clk     (clk),
        .rst     (rst),
        .data_wr (data_wr),
        .part    (part),
        .din     (din),
        .sel_reg (sel_reg),
        .update  (update)
    );

    fm_busy u_busy (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .data_wr (data_wr),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// File: source/fm_busy.sv
/*
 * FM busy flag
 * Held for a fixed number of prescaled enables after each data write
 */
`default_nettype none

`include "fm_settings.svh"

module fm_busy (
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic data_wr,
    output logic busy
);

    logic                      data_wr_q;
    logic [`FM_BUSY_CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_wr_q <= 1'b0;
            busy      <= 1'b0;
            cnt       <= '0;
        end else begin
            data_wr_q <= data_wr;
            if (data_wr && !data_wr_q) begin // Restart on each new write
                busy <= 1'b1;
                cnt  <= '0;
            end else if (clk_en) begin
                if (&cnt) busy <= 1'b0;
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(clk_en));

endmodule

`default_nettype wire

// File: source/fm_update_decode.sv
/*
 * FM update decoder
 * Registers a channel or operator update command on each data write
 */
`default_nettype none

`include "fm_settings.svh"

module fm_update_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    data_wr,
    input  logic                    part,
    input  logic [`FM_DIN_W-1:0]    din,
    input  fm_map_pkg::fm_reg_e     sel_reg,
    output fm_ctrl_pkg::fm_update_t update
);

    fm_map_pkg::fm_upd_e  kind, kind_q;
    logic [2:0]           ch_q;
    logic [1:0]           op_q;
    logic [`FM_DIN_W-1:0] data_q;

    always_comb begin
        kind = fm_map_pkg::upd_none;
        if (sel_reg == fm_map_pkg::reg_kon && !part) begin
            kind = fm_map_pkg::upd_keyon;
        end else if (sel_reg[1:0] != 2'b11) begin // Slot 3 of a group is unused
            casez (sel_reg)
                8'hA0, 8'hA1, 8'hA2: kind = fm_map_pkg::upd_fnum_lo;
                8'hB0, 8'hB1, 8'hB2: kind = fm_map_pkg::upd_alg;
                8'hB4, 8'hB5, 8'hB6: kind = fm_map_pkg::upd_pms;
                8'h3?: kind = fm_map_pkg::upd_dt1;
                8'h4?: kind = fm_map_pkg::upd_tl;
                8'h5?: kind = fm_map_pkg::upd_ks_ar;
                8'h6?: kind = fm_map_pkg::upd_amen_dr;
                8'h7?: kind = fm_map_pkg::upd_sr;
                8'h8?: kind = fm_map_pkg::upd_sl_rr;
                8'h9?: kind = fm_map_pkg::upd_ssgeg;
                default: kind = fm_map_pkg::upd_none;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) kind_q <= fm_map_pkg::upd_none;
        else if (data_wr) kind_q <= kind;
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            ch_q   <= {part, sel_reg[1:0]};
            op_q   <= sel_reg[3:2]; // Slot order S1, S3, S2, S4
            data_q <= din;
        end
    end

    assign update = '{kind: kind_q, ch: ch_q, op: op_q, data: data_q};

    a_no_ch3_slot: assert property (@(posedge clk) disable iff (rst)
        update.kind != fm_map_pkg::upd_none && update.kind != fm_map_pkg::upd_keyon
        |-> update.ch[1:0] != 2'b11);

endmodule

`default_nettype wire

// File: source/fm_global_regs.sv
/*
 * FM global registers
 * Address latch, prescaler select, timer, LFO, DAC and channel-3 registers
 */
`default_nettype none

`include "fm_settings.svh"

module fm_global_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clk_en,
    input  logic [`FM_DIN_W-1:0]   din,
    input  logic                   write,
    input  logic [1:0]             addr,
    output logic [1:0]             div_setting,
    output fm_map_pkg::fm_reg_e    sel_reg,
    output logic                   part,
    output logic                   data_wr,
    output fm_ctrl_pkg::fm_timer_t timer,
    output fm_ctrl_pkg::fm_lfo_t   lfo,
    output fm_ctrl_pkg::fm_test_t  test,
    output fm_ctrl_pkg::fm_pcm_t   pcm,
    output fm_ctrl_pkg::fm_ch3_t   ch3
);

    localparam int lat_w = `FM_BLOCK_W + `FM_FNUM_W - `FM_DIN_W;

    logic                  addr_wr;
    logic                  eg_stop, pg_stop, fast_timers;
    logic                  lfo_en;
    logic [2:0]            lfo_freq;
    logic                  ta_load, tb_load, ta_irq_en, tb_irq_en, ta_clr, tb_clr;
    logic                  effect, csm;
    logic                  pcm_en, pcm_wr;
    logic [`FM_TA_W-1:0]   ta_val;
    logic [`FM_TB_W-1:0]   tb_val;
    logic [`FM_PCM_W-1:0]  pcm_sample;
    logic [lat_w-1:0]      fnum_latch; // Shared by all channels
    logic [`FM_BLOCK_W-1:0] blk_op1, blk_op2, blk_op3;
    logic [`FM_FNUM_W-1:0] fnum_op1, fnum_op2, fnum_op3;

    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_reg     <= fm_map_pkg::fm_reg_e'(8'h00);
            part        <= 1'b0;
            div_setting <= `FM_DIV_RESET;
            {eg_stop, pg_stop, fast_timers} <= 3'b000;
            {lfo_en, lfo_freq} <= 4'h0;
            {tb_clr, ta_clr, tb_irq_en, ta_irq_en, tb_load, ta_load} <= 6'h00;
            {effect, csm} <= 2'b00;
            {pcm_en, pcm_wr} <= 2'b00;
        end else if (addr_wr) begin
            sel_reg <= fm_map_pkg::fm_reg_e'(din);
            part    <= addr[1];
            // Selecting the register alone changes the divider
            case (din)
                fm_map_pkg::reg_div_6: div_setting[1] <= 1'b1;
                fm_map_pkg::reg_div_3: div_setting[0] <= 1'b1;
                fm_map_pkg::reg_div_2: div_setting    <= 2'b00;
                default: ;
            endcase
        end else if (data_wr) begin
            if (!part) begin
                case (sel_reg)
                    fm_map_pkg::reg_test: begin
                        eg_stop     <= din[5];
                        pg_stop     <= din[3];
                        fast_timers <= din[2];
                    end
                    fm_map_pkg::reg_lfo:    {lfo_en, lfo_freq} <= din[3:0];
                    fm_map_pkg::reg_timer: begin
                        effect <= |din[7:6];
                        csm    <= din[7:6] == 2'b10; // CSM implies effect mode
                        {tb_clr, ta_clr, tb_irq_en, ta_irq_en, tb_load, ta_load} <= din[5:0];
                    end
                    fm_map_pkg::reg_dac_en: pcm_en <= din[7];
                    default: ;
                endcase
            end
            pcm_wr <= !part && sel_reg == fm_map_pkg::reg_dac;
        end else if (clk_en) begin
            // One-shot bits
            ta_clr <= 1'b0;
            tb_clr <= 1'b0;
            pcm_wr <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            if (!part) begin
                case (sel_reg)
                    fm_map_pkg::reg_clka_hi:  ta_val[`FM_TA_W-1:2] <= din;
                    fm_map_pkg::reg_clka_lo:  ta_val[1:0]          <= din[1:0];
                    fm_map_pkg::reg_clkb:     tb_val               <= din;
                    // Offset binary to signed, LSB forced high
                    fm_map_pkg::reg_dac:      pcm_sample <= {~din[`FM_DIN_W-1], din[`FM_DIN_W-2:0], 1'b1};
                    fm_map_pkg::reg_dac_test: pcm_sample[0] <= din[3];
                    fm_map_pkg::reg_ch3_op1:  {blk_op1, fnum_op1} <= {fnum_latch, din};
                    fm_map_pkg::reg_ch3_op2:  {blk_op2, fnum_op2} <= {fnum_latch, din};
                    fm_map_pkg::reg_ch3_op3:  {blk_op3, fnum_op3} <= {fnum_latch, din};
                    default: ;
                endcase
            end
            case (sel_reg)
                8'hA4, 8'hA5, 8'hA6, 8'hAC, 8'hAD, 8'hAE: fnum_latch <= din[lat_w-1:0];
                default: ;
            endcase
        end
    end

    assign timer = '{value_a: ta_val, value_b: tb_val, load_a: ta_load, load_b: tb_load,
                     irq_en_a: ta_irq_en, irq_en_b: tb_irq_en, clr_a: ta_clr,
                     clr_b: tb_clr, fast: fast_timers};
    assign lfo   = '{en: lfo_en, freq: lfo_freq};
    assign test  = '{eg_stop: eg_stop, pg_stop: pg_stop};
    assign pcm   = '{sample: pcm_sample, en: pcm_en, wr: pcm_wr};
    assign ch3   = '{effect: effect, csm: csm,
                     block_op1: blk_op1, fnum_op1: fnum_op1,
                     block_op2: blk_op2, fnum_op2: fnum_op2,
                     block_op3: blk_op3, fnum_op3: fnum_op3};

    // DAC strobe must drop on the first idle enable
    a_pcm_wr_short: assert property (@(posedge clk) disable iff (rst)
        pcm_wr && clk_en && !write |=> !pcm_wr);

endmodule

`default_nettype wire

// File: source/fm_prescaler.sv
/*
 * FM prescaler
 * Derives the FM clock enable from cen, divided by 6, 3 or 2
 */
`default_nettype none

`include "fm_settings.svh"

module fm_prescaler (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [1:0] div_setting,
    output logic       clk_en
);

    logic [2:0] cnt;
    logic [2:0] last; // Terminal count

    always_comb begin
        case (div_setting)
            2'b10:   last = 3'd5; // 1/6
            2'b11:   last = 3'd2; // 1/3
            default: last = 3'd1; // 1/2
        endcase
    end

    // >= so a smaller divider mid-count still wraps at once
    assign clk_en = cen && (cnt >= last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen) begin
            cnt <= clk_en ? 3'd0 : cnt + 3'd1;
        end
    end

    // Divider never drops below 2
    a_en_spacing: assert property (@(posedge clk) disable iff (rst) clk_en |=> !clk_en);

endmodule

`default_nettype wire

// File: source/fm_ctrl_pkg.sv
/*
 * FM control output package
 * Grouped timer, LFO, test, DAC, channel-3 and update fields
 */
`default_nettype none

`include "fm_settings.svh"

package fm_ctrl_pkg;

    typedef struct packed {
        logic [`FM_TA_W-1:0] value_a;
        logic [`FM_TB_W-1:0] value_b;
        logic                load_a;
        logic                load_b;
        logic                irq_en_a;
        logic                irq_en_b;
        logic                clr_a;    // One-shot
        logic                clr_b;    // One-shot
        logic                fast;
    } fm_timer_t;

    typedef struct packed {
        logic       en;
        logic [2:0] freq;
    } fm_lfo_t;

    typedef struct packed {
        logic eg_stop;
        logic pg_stop;
    } fm_test_t;

    typedef struct packed {
        logic [`FM_PCM_W-1:0] sample;
        logic                 en;
        logic                 wr; // Pulse per DAC write
    } fm_pcm_t;

    // Independent frequencies in channel-3 effect mode
    typedef struct packed {
        logic                   effect;
        logic                   csm;
        logic [`FM_BLOCK_W-1:0] block_op1;
        logic [`FM_FNUM_W-1:0]  fnum_op1;
        logic [`FM_BLOCK_W-1:0] block_op2;
        logic [`FM_FNUM_W-1:0]  fnum_op2;
        logic [`FM_BLOCK_W-1:0] block_op3;
        logic [`FM_FNUM_W-1:0]  fnum_op3;
    } fm_ch3_t;

    typedef struct packed {
        fm_map_pkg::fm_upd_e   kind;
        logic [2:0]            ch;   // Part bit, then register bits 1:0
        logic [1:0]            op;   // Register bits 3:2
        logic [`FM_DIN_W-1:0]  data;
    } fm_update_t;

endpackage

`default_nettype wire

// File: source/fm_map_pkg.sv
/*
 * FM register map package
 * Global register addresses and update command kinds
 */
`default_nettype none

package fm_map_pkg;

    // Global registers, part 0 unless noted
    typedef enum logic [7:0] {
        reg_test     = 8'h21,
        reg_lfo      = 8'h22,
        reg_clka_hi  = 8'h24, // Timer A bits 9:2
        reg_clka_lo  = 8'h25, // Timer A bits 1:0
        reg_clkb     = 8'h26,
        reg_timer    = 8'h27, // Load, irq, clear, mode
        reg_kon      = 8'h28,
        reg_dac      = 8'h2A,
        reg_dac_en   = 8'h2B,
        reg_dac_test = 8'h2C,
        reg_div_6    = 8'h2D, // Prescaler selects
        reg_div_3    = 8'h2E,
        reg_div_2    = 8'h2F,
        reg_ch3_op3  = 8'hA8,
        reg_ch3_op1  = 8'hA9,
        reg_ch3_op2  = 8'hAA
    } fm_reg_e;

    // What the operator register file should update
    typedef enum logic [3:0] {
        upd_none,
        upd_fnum_lo, // Channel registers
        upd_alg,
        upd_pms,
        upd_dt1,     // Operator registers
        upd_tl,
        upd_ks_ar,
        upd_amen_dr,
        upd_sr,
        upd_sl_rr,
        upd_ssgeg,
        upd_keyon
    } fm_upd_e;

endpackage

`default_nettype wire

// File: source/fm_settings.svh
/*
 * FM register interface settings
 * Widths, busy length and prescaler reset value
 */
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// Host and register widths
`define FM_DIN_W      8
`define FM_TA_W       10
`define FM_TB_W       8
`define FM_PCM_W      9
`define FM_FNUM_W     11
`define FM_BLOCK_W    3

// Busy lasts 2**FM_BUSY_CNT_W prescaled enables
`define FM_BUSY_CNT_W 5

// Divide by 6 out of reset
`define FM_DIV_RESET  2'b10

`endif
